// File: files.f
+incdir+common
common/mmio_pkg.sv
verilog/sync_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/button_events.sv
verilog/mmio_regs.sv
verilog/mmio_top.sv
dv/tb_mmio.sv

// File: Bender.yml
package:
  name: mmio

sources:
  - include_dirs:
      - common
    files:
      - common/mmio_pkg.sv
      - verilog/sync_fifo.sv
      - uart/uart_tx.sv
      - uart/uart_rx.sv
      - verilog/button_events.sv
      - verilog/mmio_regs.sv
      - verilog/mmio_top.sv
      - target: test
        files:
          - dv/tb_mmio.sv

// File: dv/tb_mmio.sv
`timescale 1ns/1ps
`include "mmio_cfg.svh"

module tb_mmio;
    localparam int NUM_BYTES       = 8;
    localparam int FRAME_CYCLES    = 10 * `MMIO_CLKS_PER_BIT;
    localparam int WATCHDOG_CYCLES = NUM_BYTES * FRAME_CYCLES * 10; // Loopback plus polling
    localparam int ACK_LIMIT       = 8;
    localparam int POLL_LIMIT      = 2 * FRAME_CYCLES;

    logic               clk;
    logic               arst_n;
    logic               req;
    mmio_pkg::bus_req_t bus;
    logic               ack;
    mmio_pkg::word_t    rdata;
    mmio_pkg::btn_t     buttons;
    mmio_pkg::sw_t      switches;
    mmio_pkg::led_t     leds;
    logic               serial_line; // Transmit looped back to receive

    int                 seed = 92473;
    longint             edge_count = 0;
    longint             last_ack_edge;

    mmio_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .bus       (bus),
        .ack       (ack),
        .rdata     (rdata),
        .buttons   (buttons),
        .switches  (switches),
        .leds      (leds),
        .serial_rx (serial_line),
        .serial_tx (serial_line)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            abort_run($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
        end
    endtask

    // One four-phase handshake that takes rdata once ack is seen
    task automatic handshake(input mmio_pkg::bus_req_t r, output mmio_pkg::word_t data);
        int waited;
        waited = 0;
        @(posedge clk);
        assert (!ack) else abort_run("Bus slave held ack high before a new request");
        req <= 1'b1;
        bus <= r;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < ACK_LIMIT);
        assert (ack) else abort_run("Bus slave did not raise ack after req went high");
        data          = rdata;
        last_ack_edge = edge_count;
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (ack) begin
                assert (rdata === data) else abort_run("Read data changed while ack was high");
            end
        end while (ack && waited < ACK_LIMIT);
        assert (!ack) else abort_run("Bus slave did not drop ack after req went low");
    endtask

    task automatic bus_write(input logic [`MMIO_ADDR_W-1:0] addr, input mmio_pkg::word_t wdata);
        mmio_pkg::word_t unused;
        handshake('{we: 1'b1, addr: addr, wdata: wdata}, unused);
    endtask

    task automatic bus_read(input logic [`MMIO_ADDR_W-1:0] addr, output mmio_pkg::word_t data);
        handshake('{we: 1'b0, addr: addr, wdata: '0}, data);
    endtask

    // Reads addr until the given bit reaches value
    task automatic poll_bit(input logic [`MMIO_ADDR_W-1:0] addr, input int bit_pos,
                            input logic value, input string what);
        mmio_pkg::word_t d;
        int              tries;
        tries = 0;
        bus_read(addr, d);
        while (d[bit_pos] !== value) begin
            tries++;
            assert (tries <= POLL_LIMIT) else abort_run($sformatf("Gave up waiting for %s", what));
            bus_read(addr, d);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Watchdog expired before all tests finished");
    end

    initial begin
        mmio_pkg::word_t d;
        mmio_pkg::byte_t sent [NUM_BYTES];
        mmio_pkg::word_t led_val;
        mmio_pkg::sw_t   sw_val;
        mmio_pkg::btn_t  btn_pat;
        mmio_pkg::btn_t  btn_extra;
        longint          clr_edge;
        int              gap;

        arst_n   = 1'b0;
        req      = 1'b0;
        bus      = '0;
        buttons  = '0;
        switches = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        // Reset state
        check_value("reset ack", 32'd0, 32'(ack));
        check_value("reset leds", 32'd0, 32'(leds));
        check_value("reset serial_tx", 32'd1, 32'(serial_line));
        bus_read(`MMIO_UART_CTRL, d);
        check_value("reset uart ctrl", 32'd1, d);
        bus_read(`MMIO_UART_RX, d);
        check_value("empty uart rx", 32'd0, d);

        // Switches, LEDs and unmapped offsets
        do begin
            led_val = $random(seed);
        end while (led_val[5:0] == 6'd0);
        do begin
            sw_val = 2'($random(seed));
        end while (sw_val == 2'd0);
        @(posedge clk);
        switches <= sw_val;
        bus_write(`MMIO_LEDS, led_val);
        check_value("led write", 32'(led_val[5:0]), 32'(leds));
        bus_read(`MMIO_SWITCHES, d);
        check_value("switch read", 32'(sw_val), d);
        bus_read(8'h3C, d);
        check_value("unmapped read", 32'd0, d);

        // UART loopback
        for (int i = 0; i < NUM_BYTES; i++) begin
            poll_bit(`MMIO_UART_CTRL, 0, 1'b1, "transmit ready");
            sent[i] = 8'($random(seed));
            bus_write(`MMIO_UART_TX, 32'(sent[i]));
        end
        for (int i = 0; i < NUM_BYTES; i++) begin
            poll_bit(`MMIO_UART_CTRL, 1, 1'b1, "received byte");
            bus_read(`MMIO_UART_RX, d);
            check_value($sformatf("loopback byte %0d", i), 32'(sent[i]), d);
        end
        bus_read(`MMIO_UART_CTRL, d);
        check_value("rx valid after drain", 32'd0, 32'(d[1]));

        // Cycle counter reads back n-1 after n edges between the two acks
        bus_write(`MMIO_CNT_CLR, 32'd0);
        clr_edge = last_ack_edge;
        gap      = 5 + ($random(seed) & 31);
        repeat (gap) @(posedge clk);
        bus_read(`MMIO_CYCLE, d);
        check_value("cycle counter", 32'(last_ack_edge - clr_edge - 1), d);

        // Buttons
        do begin
            btn_pat = 4'($random(seed));
        end while (btn_pat == 4'h0 || btn_pat == 4'hF);
        btn_extra = '0;
        for (int i = 0; i < 4; i++) begin
            if (!btn_pat[i] && btn_extra == '0) begin
                btn_extra = 4'(1 << i);
            end
        end
        @(posedge clk);
        buttons <= btn_pat;
        poll_bit(`MMIO_BTN_STAT, 0, 1'b0, "button event");
        bus_read(`MMIO_BTN_DATA, d);
        check_value("button press", 32'(btn_pat), d);
        bus_read(`MMIO_BTN_STAT, d);
        check_value("button fifo empty", 32'd1, d);
        repeat (10) @(posedge clk); // Held buttons must not repeat
        bus_read(`MMIO_BTN_STAT, d);
        check_value("button held no repeat", 32'd1, d);
        @(posedge clk);
        buttons <= btn_pat | btn_extra;
        poll_bit(`MMIO_BTN_STAT, 0, 1'b0, "second button event");
        bus_read(`MMIO_BTN_DATA, d);
        check_value("second button press", 32'(btn_extra), d);
        bus_read(`MMIO_BTN_STAT, d);
        check_value("button fifo empty again", 32'd1, d);

        $display("Test OK");
        $finish;
    end

endmodule

// File: verilog/mmio_top.sv
`timescale 1ns/1ps
`include "mmio_cfg.svh"

module mmio_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               req,
    input  mmio_pkg::bus_req_t bus,
    output logic               ack,
    output mmio_pkg::word_t    rdata,
    input  mmio_pkg::btn_t     buttons,
    input  mmio_pkg::sw_t      switches,
    output mmio_pkg::led_t     leds,
    input  logic               serial_rx,
    output logic               serial_tx
);
    localparam int BTN_W = $bits(mmio_pkg::btn_t);

    logic            tx_push;
    logic            tx_pop;
    logic            tx_full;
    logic            tx_empty;
    mmio_pkg::byte_t tx_din;
    mmio_pkg::byte_t tx_dout;

    logic            rx_push;
    logic            rx_pop;
    logic            rx_full;
    logic            rx_empty;
    mmio_pkg::byte_t rx_din;
    mmio_pkg::byte_t rx_dout;

    logic            btn_push;
    logic            btn_pop;
    logic            btn_full;
    logic            btn_empty;
    mmio_pkg::btn_t  btn_din;
    mmio_pkg::btn_t  btn_dout;

    mmio_regs regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .bus       (bus),
        .ack       (ack),
        .rdata     (rdata),
        .switches  (switches),
        .leds      (leds),
        .tx_full   (tx_full),   // From tx_fifo
        .tx_push   (tx_push),   // To tx_fifo
        .tx_data   (tx_din),    // To tx_fifo
        .rx_empty  (rx_empty),  // From rx_fifo
        .rx_data   (rx_dout),   // From rx_fifo
        .rx_pop    (rx_pop),    // To rx_fifo
        .btn_empty (btn_empty), // From btn_fifo
        .btn_data  (btn_dout),  // From btn_fifo
        .btn_pop   (btn_pop)    // To btn_fifo
    );

    sync_fifo #(
        .WIDTH (8),
        .DEPTH (`MMIO_FIFO_DEPTH)
    ) tx_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr_en  (tx_push),
        .din    (tx_din),
        .full   (tx_full),
        .rd_en  (tx_pop),   // From on_chip_tx
        .dout   (tx_dout),  // To on_chip_tx
        .empty  (tx_empty)
    );

    sync_fifo #(
        .WIDTH (8),
        .DEPTH (`MMIO_FIFO_DEPTH)
    ) rx_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr_en  (rx_push),  // From on_chip_rx
        .din    (rx_din),   // From on_chip_rx
        .full   (rx_full),
        .rd_en  (rx_pop),
        .dout   (rx_dout),
        .empty  (rx_empty)
    );

    sync_fifo #(
        .WIDTH (BTN_W),
        .DEPTH (`MMIO_FIFO_DEPTH)
    ) btn_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr_en  (btn_push), // From gpio_buttons
        .din    (btn_din),  // From gpio_buttons
        .full   (btn_full),
        .rd_en  (btn_pop),
        .dout   (btn_dout),
        .empty  (btn_empty)
    );

    uart_tx on_chip_tx (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (tx_empty),
        .data      (tx_dout),
        .pop       (tx_pop),
        .serial_tx (serial_tx)
    );

    uart_rx on_chip_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .serial_rx (serial_rx),
        .full      (rx_full),
        .push      (rx_push),
        .data      (rx_din)
    );

    button_events gpio_buttons (
        .clk     (clk),
        .arst_n  (arst_n),
        .buttons (buttons),
        .full    (btn_full),
        .push    (btn_push),
        .data    (btn_din)
    );

endmodule

// File: verilog/mmio_regs.sv
`timescale 1ns/1ps
`include "mmio_cfg.svh"

module mmio_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req,
    input  mmio_pkg::bus_req_t   bus,
    output logic                 ack,
    output mmio_pkg::word_t      rdata,
    input  mmio_pkg::sw_t        switches,
    output mmio_pkg::led_t       leds,
    input  logic                 tx_full,
    output logic                 tx_push,
    output mmio_pkg::byte_t      tx_data,
    input  logic                 rx_empty,
    input  mmio_pkg::byte_t      rx_data,
    output logic                 rx_pop,
    input  logic                 btn_empty,
    input  mmio_pkg::btn_t       btn_data,
    output logic                 btn_pop
);
    logic            access; // Edge that performs the access and raises ack
    logic            rd_access;
    logic            wr_access;
    logic            cnt_clr;
    logic            led_we;
    mmio_pkg::word_t rd_word;
    mmio_pkg::word_t cycle_cnt;

    assign access    = req && !ack;
    assign rd_access = access && !bus.we;
    assign wr_access = access && bus.we;

    // Write strobes
    assign tx_push = wr_access && (bus.addr == `MMIO_UART_TX) && !tx_full;
    assign tx_data = bus.wdata[7:0];
    assign cnt_clr = wr_access && (bus.addr == `MMIO_CNT_CLR);
    assign led_we  = wr_access && (bus.addr == `MMIO_LEDS);

    // Read pops land on the ack edge
    assign rx_pop  = rd_access && (bus.addr == `MMIO_UART_RX) && !rx_empty;
    assign btn_pop = rd_access && (bus.addr == `MMIO_BTN_DATA) && !btn_empty;

    always_comb begin
        rd_word = '0; // Unmapped and write-only offsets read as zero
        case (bus.addr)
            `MMIO_UART_CTRL: rd_word = {30'd0, !rx_empty, !tx_full};
            `MMIO_UART_RX: begin
                if (!rx_empty) begin
                    rd_word = mmio_pkg::word_t'(rx_data);
                end
            end
            `MMIO_CYCLE:     rd_word = cycle_cnt;
            `MMIO_BTN_STAT:  rd_word = {31'd0, btn_empty};
            `MMIO_BTN_DATA: begin
                if (!btn_empty) begin
                    rd_word = mmio_pkg::word_t'(btn_data);
                end
            end
            `MMIO_SWITCHES:  rd_word = mmio_pkg::word_t'(switches);
            default:         rd_word = '0;
        endcase
    end

    // Read data is captured once per handshake and held with ack
    always_ff @(posedge clk) begin
        if (access) begin
            rdata <= bus.we ? '0 : rd_word;
        end
    end

    // Four-phase slave state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else if (access) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0; // Master released req
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= '0;
        end else if (cnt_clr) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;
        end else if (led_we) begin
            leds <= bus.wdata[5:0];
        end
    end

endmodule

// File: verilog/button_events.sv
`timescale 1ns/1ps

module button_events (
    input  logic           clk,
    input  logic           arst_n,
    input  mmio_pkg::btn_t buttons,
    input  logic           full,
    output logic           push,
    output mmio_pkg::btn_t data
);
    mmio_pkg::btn_t sync_0;
    mmio_pkg::btn_t sync_1;
    mmio_pkg::btn_t prev; // Level seen one cycle earlier

    // Buttons that just went from released to pressed
    assign data = sync_1 & ~prev;
    assign push = (data != '0) && !full; // Event lost when FIFO is full

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_0 <= '0;
            sync_1 <= '0;
            prev   <= '0;
        end else begin
            sync_0 <= buttons;
            sync_1 <= sync_0;
            prev   <= sync_1;
        end
    end

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/1ps
`include "mmio_cfg.svh"

module uart_rx (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            serial_rx,
    input  logic            full,
    output logic            push,
    output mmio_pkg::byte_t data
);
    localparam int CPB   = `MMIO_CLKS_PER_BIT;
    localparam int HALF  = (CPB > 1) ? CPB / 2 : 1;
    localparam int CNT_W = (CPB > 1) ? $clog2(CPB) : 1;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [1:0]       line_sync; // Bit 1 is the synchronised line
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             sample_data;
    mmio_pkg::byte_t  shreg;

    assign sample_data = (state == RX_DATA) && (clk_cnt == CNT_W'(CPB - 1));
    assign data        = shreg; // Stable until the next frame's data bits

    always_ff @(posedge clk) begin
        if (sample_data) begin
            shreg <= {line_sync[1], shreg[7:1]}; // LSB arrives first
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_sync <= 2'b11;
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            push      <= 1'b0;
        end else begin
            line_sync <= {line_sync[0], serial_rx};
            push      <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!line_sync[1]) begin
                        state <= RX_START; // Falling edge of start bit
                    end
                end
                RX_START: begin
                    if (clk_cnt == CNT_W'(HALF - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // A glitch that is high again at mid-bit is not a frame
                        state   <= line_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                RX_DATA: begin
                    if (sample_data) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                default: begin
                    if (clk_cnt == CNT_W'(CPB - 1)) begin
                        clk_cnt <= '0;
                        state   <= RX_IDLE;
                        push    <= line_sync[1] && !full; // Framing error or full drops it
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
            endcase
        end
    end

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps
`include "mmio_cfg.svh"

module uart_tx (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          empty,
    input  mmio_pkg::byte_t data,
    output logic          pop,
    output logic          serial_tx
);
    localparam int CPB   = `MMIO_CLKS_PER_BIT;
    localparam int CNT_W = (CPB > 1) ? $clog2(CPB) : 1;

    logic             busy;
    logic [CNT_W-1:0] clk_cnt; // Cycles into the current bit
    logic [3:0]       bit_idx; // 0 start, 1..8 data, 9 stop
    logic [9:0]       shreg;

    // Take the head as soon as the line is free
    assign pop       = !busy && !empty;
    assign serial_tx = shreg[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            shreg   <= '1; // Line idles high
        end else if (!busy) begin
            if (!empty) begin
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
                shreg   <= {1'b1, data, 1'b0}; // Stop, data LSB first, start
            end
        end else if (clk_cnt == CNT_W'(CPB - 1)) begin
            clk_cnt <= '0;
            shreg   <= {1'b1, shreg[9:1]};
            if (bit_idx == 4'd9) begin
                busy    <= 1'b0; // Stop bit done
                bit_idx <= '0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + CNT_W'(1);
        end
    end

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full; // Push while full is dropped
    assign do_rd = rd_en && !empty;
    assign dout  = mem[rd_ptr]; // Head shown without a read cycle

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count; // Both or neither
            endcase
        end
    end

endmodule

// File: common/mmio_pkg.sv
`include "mmio_cfg.svh"

package mmio_pkg;

    typedef logic [31:0] word_t; // Bus data word
    typedef logic [7:0]  byte_t; // UART byte
    typedef logic [3:0]  btn_t;
    typedef logic [1:0]  sw_t;
    typedef logic [5:0]  led_t;

    // Request side of the peripheral bus, held stable while req is high
    typedef struct packed {
        logic                    we;
        logic [`MMIO_ADDR_W-1:0] addr;  // Byte offset
        word_t                   wdata;
    } bus_req_t;

endpackage

// File: common/mmio_cfg.svh
`ifndef MMIO_CFG_SVH
`define MMIO_CFG_SVH

// Clocking and serial rate
`define MMIO_CLK_FREQ      25_000_000
`define MMIO_BAUD          1_000_000
`define MMIO_CLKS_PER_BIT  (`MMIO_CLK_FREQ / `MMIO_BAUD)

// Depth shared by the transmit, receive and button FIFOs
`define MMIO_FIFO_DEPTH    32

`define MMIO_ADDR_W        8

// Register offsets
`define MMIO_UART_CTRL     8'h00 // Bit 0 tx ready, bit 1 rx valid
`define MMIO_UART_RX       8'h04
`define MMIO_UART_TX       8'h08
`define MMIO_CYCLE         8'h10
`define MMIO_CNT_CLR       8'h18
`define MMIO_BTN_STAT      8'h20 // Bit 0 empty
`define MMIO_BTN_DATA      8'h24
`define MMIO_SWITCHES      8'h28
`define MMIO_LEDS          8'h30

`endif
